/* verilog.f */
source/qspi_flash_pkg.sv
source/qspi_ctrl_pkg.sv
source/qspi_addr_tracker.sv
source/qspi_burst_sequencer.sv
source/qspi_serial_shifter.sv
source/qspi_read_buffer.sv
source/qspi_flash_reader.sv
test/qspi_flash_reader_assertions.sv
test/qspi_flash_reader_tb.sv

/* test/qspi_flash_reader_tb.sv */
// Three bursts against a four-chip flash model; checking is done by the bound checker
`timescale 1ns/1ps

module qspi_flash_reader_tb;

	logic clk;
	logic nreset;
	logic [21:0] addr_in;
	logic [21:0] stop_addr_in;
	logic addr_sload;
	logic data_request;
	logic data_read;
	logic flash_access_granted;
	logic [15:0] data;
	logic data_ready;
	logic done;
	logic flash_access_request;
	logic flash_sck;
	logic [3:0] flash_ncs;
	logic [3:0] flash_io_out;
	logic [3:0] flash_highz;
	logic [3:0] flash_io0_in;
	logic [3:0] flash_io1_in;
	logic [3:0] flash_io2_in;
	logic [3:0] flash_io3_in;

	logic [20:0] model_base; // Start word of the burst
	logic [15:0] model_k; // Read clocks given so far
	logic [15:0] model_word;
	int limit_cycles = 0;

	qspi_flash_reader dut0 (.*);

	always #50 clk = ~clk;

	// **************************************************
	// Flash model
	// **************************************************

	assign model_word = model_base[15:0] + model_k;

	always_comb begin
		for (int c = 0; c < 4; c++) begin
			flash_io0_in[c] = model_word[4*c + 3];
			flash_io1_in[c] = model_word[4*c + 2];
			flash_io2_in[c] = model_word[4*c + 1];
			flash_io3_in[c] = model_word[4*c];
		end
	end

	// Next word goes out after each read clock
	always @(negedge flash_sck or posedge flash_ncs[0]) begin
		if (flash_ncs[0]) begin
			model_k <= '0;
		end else if (flash_highz[0]) begin
			model_k <= model_k + 16'd1;
		end
	end

	task automatic report_failure();
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		if (dut0.checks0.fail_count != 0) begin
			report_failure();
		end
	end

	initial begin
		wait (limit_cycles > 0);
		#(limit_cycles * 100);
		$display("Timeout, the bursts did not complete in time");
		report_failure();
	end

	task automatic run_burst(input logic [21:0] start, input int len, input int withhold);
		@(posedge clk);
		#5;
		addr_in = start;
		stop_addr_in = start + 22'(2 * (len - 1));
		addr_sload = 1'b1;
		model_base = start[21:1];
		@(posedge clk);
		#5;
		addr_sload = 1'b0;
		data_request = 1'b1;
		flash_access_granted = (withhold == 0);
		repeat (withhold) @(posedge clk);
		#5;
		flash_access_granted = 1'b1;
		do begin
			@(posedge clk);
			#5;
			if (done) begin
				data_read = 1'b0;
			end else begin
				data_read = data_ready && (($urandom % 3) != 0); // Random stalls
			end
		end while (!done);
		data_request = 1'b0;
		flash_access_granted = 1'b0;
		repeat (6) @(posedge clk);
	endtask

	initial begin
		logic [21:0] starts [3];
		int lens [3];
		int holds [3];
		clk = 1'b0;
		nreset = 1'b0;
		addr_in = '0;
		stop_addr_in = '0;
		addr_sload = 1'b0;
		data_request = 1'b0;
		data_read = 1'b0;
		flash_access_granted = 1'b0;
		model_base = '0;
		model_k = '0;
		void'($urandom(48));
		holds = '{0, 20, 0}; // Second burst waits for the arbiter
		for (int i = 0; i < 3; i++) begin
			starts[i] = 22'($urandom) & 22'h3FFFFE;
			lens[i] = 3 + ($urandom % 8);
		end
		for (int i = 0; i < 3; i++) begin
			limit_cycles += 3 * (270 + 10 * lens[i] + holds[i]);
		end
		limit_cycles += 40;
		repeat (4) @(posedge clk);
		#5;
		nreset = 1'b1;
		repeat (3) @(posedge clk);
		for (int i = 0; i < 3; i++) begin
			run_burst(starts[i], lens[i], holds[i]);
		end
		if (dut0.checks0.fail_count == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			report_failure();
		end
	end

endmodule

/* test/qspi_flash_reader_assertions.sv */
// Bound checker for qspi_flash_reader; assumes one burst at a time and no restart mid-burst
`timescale 1ns/1ps

module qspi_flash_reader_assertions (
	input logic clk,
	input logic nreset,
	input logic [21:0] addr_in,
	input logic [21:0] stop_addr_in,
	input logic addr_sload,
	input logic data_request,
	input logic data_read,
	input logic [15:0] data,
	input logic data_ready,
	input logic done,
	input logic flash_access_request,
	input logic flash_access_granted,
	input logic flash_sck,
	input logic [3:0] flash_ncs,
	input logic [3:0] flash_io_out,
	input logic [3:0] flash_highz
);

	int fail_count = 0; // Failed checks so far
	logic [1:0] win; // Chip-select window within a burst
	logic [5:0] cmd_cnt; // Driven clocks in the window
	logic [15:0] io0_bits;
	logic [23:0] nib_bits;
	logic [23:0] exp_addr;
	logic [20:0] exp_word;
	logic granted_seen;
	logic req_seen;

	// **************************************************
	// Serial stream capture
	// **************************************************

	always @(posedge flash_sck or posedge flash_ncs[0] or negedge nreset) begin
		if (!nreset) begin
			win <= 2'd0;
			cmd_cnt <= '0;
			io0_bits <= '0;
			nib_bits <= '0;
		end else if (flash_ncs[0]) begin
			win <= (win == 2'd2) ? 2'd0 : win + 2'd1; // Window closed
			cmd_cnt <= '0;
		end else if (!flash_highz[0]) begin
			cmd_cnt <= cmd_cnt + 6'd1;
			io0_bits <= {io0_bits[14:0], flash_io_out[0]};
			nib_bits <= {nib_bits[19:0], flash_io_out};
		end
	end

	always @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			exp_addr <= '0;
			exp_word <= '0;
			granted_seen <= 1'b0;
			req_seen <= 1'b0;
		end else begin
			if (addr_sload) begin
				exp_addr <= 24'(addr_in >> 2); // Per-chip address
				exp_word <= addr_in[21:1];
			end else if (data_ready && data_read) begin
				exp_word <= exp_word + 21'd1;
			end
			if (!data_request && !flash_access_request) begin
				granted_seen <= 1'b0;
			end else if (data_request && flash_access_granted) begin
				granted_seen <= 1'b1;
			end
			if (data_request) begin
				req_seen <= 1'b1;
			end
		end
	end

	// **************************************************
	// Checks
	// **************************************************

	a_idle_after_reset: assert property (@(posedge clk) disable iff (!nreset)
		!req_seen |-> (&flash_ncs && !flash_sck && (flash_highz == 4'b0000)
			&& !flash_access_request && !data_ready && !done))
		else begin
			$error("outputs not idle after reset before the first data request");
			fail_count = fail_count + 1;
		end

	a_request_delay: assert property (@(posedge clk) disable iff (!nreset)
		flash_access_request == $past(data_request))
		else begin
			$error("FAIL flash_access_request got %h expected %h",
				flash_access_request, $past(data_request));
			fail_count = fail_count + 1;
		end

	a_ncs_after_grant: assert property (@(posedge clk) disable iff (!nreset)
		!flash_ncs[0] |-> granted_seen)
		else begin
			$error("flash chip select went low before the access grant");
			fail_count = fail_count + 1;
		end

	// All four lanes change direction together
	a_lane_direction: assert property (@(posedge clk) disable iff (!nreset)
		(flash_sck && !flash_ncs[0]) |-> (flash_highz == {4{flash_highz[0]}}))
		else begin
			$error("flash lanes were neither all driven nor all released during a clock");
			fail_count = fail_count + 1;
		end

	a_write_enable: assert property (@(posedge clk) disable iff (!nreset)
		(win == 2'd0 && cmd_cnt == 6'd8) |-> (io0_bits[7:0] == 8'h06))
		else begin
			$error("FAIL flash_io_out got %h expected %h", io0_bits[7:0], 8'h06);
			fail_count = fail_count + 1;
		end

	a_config_write: assert property (@(posedge clk) disable iff (!nreset)
		(win == 2'd1 && cmd_cnt == 6'd16) |-> (io0_bits == 16'h81FB))
		else begin
			$error("FAIL flash_io_out got %h expected %h", io0_bits, 16'h81FB);
			fail_count = fail_count + 1;
		end

	a_read_opcode: assert property (@(posedge clk) disable iff (!nreset)
		(win == 2'd2 && cmd_cnt == 6'd8) |-> (io0_bits[7:0] == 8'hEB))
		else begin
			$error("FAIL flash_io_out got %h expected %h", io0_bits[7:0], 8'hEB);
			fail_count = fail_count + 1;
		end

	a_quad_address: assert property (@(posedge clk) disable iff (!nreset)
		(win == 2'd2 && cmd_cnt == 6'd14) |-> (nib_bits == exp_addr))
		else begin
			$error("FAIL flash_io_out got %h expected %h", nib_bits, exp_addr);
			fail_count = fail_count + 1;
		end

	// Opcode, six address and ten dummy clocks before any read clock
	a_dummy_clocks: assert property (@(posedge clk) disable iff (!nreset)
		(flash_sck && flash_highz[0] && !flash_ncs[0]) |-> (win == 2'd2 && cmd_cnt == 6'd24))
		else begin
			$error("read clock started after %0d driven clocks in window %0d", cmd_cnt, win);
			fail_count = fail_count + 1;
		end

	a_word_value: assert property (@(posedge clk) disable iff (!nreset)
		(data_ready && data_read) |-> (data == exp_word[15:0]))
		else begin
			$error("FAIL data got %h expected %h", data, exp_word[15:0]);
			fail_count = fail_count + 1;
		end

	a_word_stable: assert property (@(posedge clk) disable iff (!nreset)
		(data_ready && !data_read && data_request) |=> (data_ready && $stable(data)))
		else begin
			$error("FAIL data got %h expected %h", data, $past(data));
			fail_count = fail_count + 1;
		end

	a_done_rise: assert property (@(posedge clk) disable iff (!nreset)
		$rose(done) |-> $past(data_ready && data_read && (exp_word == stop_addr_in[21:1])))
		else begin
			$error("done rose without the stop word being read");
			fail_count = fail_count + 1;
		end

	a_done_fall: assert property (@(posedge clk) disable iff (!nreset)
		$fell(done) |-> $past(addr_sload))
		else begin
			$error("done fell without a new start address");
			fail_count = fail_count + 1;
		end

endmodule

bind qspi_flash_reader qspi_flash_reader_assertions checks0 (.*);

/* source/qspi_flash_reader.sv */
// Quad-SPI burst reader for four flash chips in parallel; lanes are tri-stated outside this block
`timescale 1ns/1ps

module qspi_flash_reader (
	input  logic clk,
	input  logic nreset,
	input  logic [qspi_ctrl_pkg::flash_addr_width-1:0] addr_in,
	input  logic [qspi_ctrl_pkg::flash_addr_width-1:0] stop_addr_in,
	input  logic addr_sload,
	input  logic data_request,
	input  logic data_read,
	output logic [qspi_flash_pkg::data_width-1:0] data,
	output logic data_ready,
	output logic done,
	output logic flash_access_request,
	input  logic flash_access_granted,
	output logic flash_sck,
	output logic [qspi_flash_pkg::n_flash-1:0] flash_ncs,
	output logic [3:0] flash_io_out,
	output logic [3:0] flash_highz,
	input  logic [qspi_flash_pkg::n_flash-1:0] flash_io0_in,
	input  logic [qspi_flash_pkg::n_flash-1:0] flash_io1_in,
	input  logic [qspi_flash_pkg::n_flash-1:0] flash_io2_in,
	input  logic [qspi_flash_pkg::n_flash-1:0] flash_io3_in
);

	qspi_ctrl_pkg::burst_state_t state;
	logic [qspi_ctrl_pkg::read_addr_width-1:0] read_address;
	logic [qspi_flash_pkg::lane_width-1:0] step_bits;
	logic [qspi_flash_pkg::count_width-1:0] step_count_load;
	logic step_shift_fill;
	logic step_clocked;
	logic step_ncs;
	logic addr_latched;
	logic granted;
	logic burst_restart;
	logic shift_done;
	logic take_word;
	logic word_taken;

	qspi_address_tracker tracker0 (
		.clk(clk), .nreset(nreset),
		.addr_in(addr_in), .stop_addr_in(stop_addr_in), .addr_sload(addr_sload),
		.data_request(data_request), .flash_access_granted(flash_access_granted),
		.word_taken(word_taken), .burst_restart(burst_restart),
		.read_address(read_address), .addr_latched(addr_latched), .granted(granted),
		.flash_access_request(flash_access_request), .done(done)
	);

	qspi_burst_sequencer sequencer0 (
		.clk(clk), .nreset(nreset), .data_request(data_request),
		.addr_latched(addr_latched), .granted(granted), .shift_done(shift_done),
		.take_word(take_word), .state(state), .step_bits(step_bits),
		.step_count_load(step_count_load), .step_shift_fill(step_shift_fill),
		.step_clocked(step_clocked), .step_ncs(step_ncs), .burst_restart(burst_restart)
	);

	qspi_serial_shifter shifter0 (
		.clk(clk), .state(state), .step_bits(step_bits), .step_count_load(step_count_load),
		.step_shift_fill(step_shift_fill), .step_clocked(step_clocked), .step_ncs(step_ncs),
		.read_address(read_address), .shift_done(shift_done), .flash_sck(flash_sck),
		.flash_ncs(flash_ncs), .flash_io_out(flash_io_out), .flash_highz(flash_highz)
	);

	qspi_read_buffer buffer0 (
		.clk(clk), .nreset(nreset), .state(state),
		.flash_io0_in(flash_io0_in), .flash_io1_in(flash_io1_in),
		.flash_io2_in(flash_io2_in), .flash_io3_in(flash_io3_in),
		.data_read(data_read), .data(data), .data_ready(data_ready),
		.take_word(take_word), .word_taken(word_taken)
	);

endmodule

/* source/qspi_read_buffer.sv */
// One-word holding stage; the sequencer only clocks the flash when a word can be accepted
`timescale 1ns/1ps

module qspi_read_buffer (
	input  logic clk,
	input  logic nreset,
	input  qspi_ctrl_pkg::burst_state_t state,
	input  logic [qspi_flash_pkg::n_flash-1:0] flash_io0_in,
	input  logic [qspi_flash_pkg::n_flash-1:0] flash_io1_in,
	input  logic [qspi_flash_pkg::n_flash-1:0] flash_io2_in,
	input  logic [qspi_flash_pkg::n_flash-1:0] flash_io3_in,
	input  logic data_read,
	output logic [qspi_flash_pkg::data_width-1:0] data,
	output logic data_ready,
	output logic take_word,
	output logic word_taken
);

	logic [qspi_flash_pkg::data_width-1:0] lane_word;
	logic capture;
	logic flush;

	// Chip 3 in the top nibble, io0 highest within a chip
	always_comb begin
		for (int c = 0; c < qspi_flash_pkg::n_flash; c++) begin
			lane_word[4*c + 3] = flash_io0_in[c];
			lane_word[4*c + 2] = flash_io1_in[c];
			lane_word[4*c + 1] = flash_io2_in[c];
			lane_word[4*c] = flash_io3_in[c];
		end
	end

	assign capture = (state == qspi_ctrl_pkg::st_read_high); // Clock is high this cycle
	assign flush = (state == qspi_ctrl_pkg::st_init) || (state == qspi_ctrl_pkg::st_wait);
	assign word_taken = data_ready & data_read;
	assign take_word = ~data_ready | data_read;

	always_ff @(posedge clk) begin
		if (capture) begin
			data <= lane_word;
		end
	end

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			data_ready <= 1'b0;
		end else if (flush) begin
			data_ready <= 1'b0; // Unread word of an aborted burst is dropped
		end else if (capture) begin
			data_ready <= 1'b1;
		end else if (data_read) begin
			data_ready <= 1'b0;
		end
	end

endmodule

/* source/qspi_serial_shifter.sv */
// Command clock runs at half the system clock; read clock is one system cycle high per word
`timescale 1ns/1ps

module qspi_serial_shifter (
	input  logic clk,
	input  qspi_ctrl_pkg::burst_state_t state,
	input  logic [qspi_flash_pkg::lane_width-1:0] step_bits,
	input  logic [qspi_flash_pkg::count_width-1:0] step_count_load,
	input  logic step_shift_fill,
	input  logic step_clocked,
	input  logic step_ncs,
	input  logic [qspi_ctrl_pkg::read_addr_width-1:0] read_address,
	output logic shift_done,
	output logic flash_sck,
	output logic [qspi_flash_pkg::n_flash-1:0] flash_ncs,
	output logic [3:0] flash_io_out,
	output logic [3:0] flash_highz
);

	logic [qspi_flash_pkg::lane_width-1:0] io0_q;
	logic [qspi_flash_pkg::addr_cycles-1:0] io_hi_q [1:3];
	logic [qspi_flash_pkg::addr_cycles-1:0] addr_lane [0:3];
	logic [qspi_flash_pkg::lane_width-1:0] io0_load;
	logic [qspi_flash_pkg::count_width-1:0] count_q;
	logic almost_done;
	logic sck_cmd; // Half-rate command clock
	logic enable_shift;
	logic addr_step;
	logic loading;
	logic shifting;
	logic read_phase;
	logic turnaround;

	assign loading = (state == qspi_ctrl_pkg::st_loading);
	assign addr_step = ~step_shift_fill; // Only the address step fills with zeros
	assign enable_shift = step_clocked ? sck_cmd : 1'b1;
	assign shifting = (state == qspi_ctrl_pkg::st_transaction) && enable_shift;

	// Address bits interleaved over the lanes, io3 carries the MSB
	always_comb begin
		for (int l = 0; l < 4; l++) begin
			for (int j = 0; j < qspi_flash_pkg::addr_cycles; j++) begin
				addr_lane[l][j] = read_address[4*j + l];
			end
		end
	end

	assign io0_load = addr_step ? (step_bits | {addr_lane[0],
		{(qspi_flash_pkg::lane_width - qspi_flash_pkg::addr_cycles){1'b0}}}) : step_bits;

	// **************************************************
	// Lane shift registers and bit counter
	// **************************************************

	always_ff @(posedge clk) begin
		if (loading) begin
			io0_q <= io0_load;
			for (int l = 1; l < 4; l++) begin
				io_hi_q[l] <= addr_step ? addr_lane[l] : '1;
			end
		end else if (shifting) begin
			io0_q <= {io0_q[qspi_flash_pkg::lane_width-2:0], step_shift_fill};
			for (int l = 1; l < 4; l++) begin
				io_hi_q[l] <= {io_hi_q[l][qspi_flash_pkg::addr_cycles-2:0], step_shift_fill};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (loading) begin
			count_q <= step_count_load;
			almost_done <= 1'b0;
		end else if (shifting) begin
			count_q <= count_q - 1'b1;
			if (count_q == '0) begin
				almost_done <= 1'b1; // One more bit to go
			end
		end
	end

	assign shift_done = almost_done & enable_shift;

	// Toggles only while a clocked step runs, otherwise parked low
	always_ff @(posedge clk) begin
		if ((state == qspi_ctrl_pkg::st_transaction) && step_clocked) begin
			sck_cmd <= ~sck_cmd;
		end else begin
			sck_cmd <= 1'b0;
		end
	end

	// **************************************************
	// Flash pins
	// **************************************************

	assign read_phase = (state == qspi_ctrl_pkg::st_read) || (state == qspi_ctrl_pkg::st_read_high);
	assign turnaround = read_phase || (state == qspi_ctrl_pkg::st_reset)
		|| (state == qspi_ctrl_pkg::st_dummy); // io1 lets go first

	assign flash_sck = sck_cmd | (state == qspi_ctrl_pkg::st_read_high);
	assign flash_ncs = {qspi_flash_pkg::n_flash{step_ncs}};
	assign flash_io_out = {
		io_hi_q[3][qspi_flash_pkg::addr_cycles-1],
		io_hi_q[2][qspi_flash_pkg::addr_cycles-1],
		io_hi_q[1][qspi_flash_pkg::addr_cycles-1],
		io0_q[qspi_flash_pkg::lane_width-1]
	};
	assign flash_highz = {read_phase, read_phase, turnaround, read_phase};

endmodule

/* source/qspi_burst_sequencer.sv */
// Fixed six-step command phase for 3-byte quad-IO reads; dropping data_request aborts at once
`timescale 1ns/1ps

module qspi_burst_sequencer (
	input  logic clk,
	input  logic nreset,
	input  logic data_request,
	input  logic addr_latched,
	input  logic granted,
	input  logic shift_done,
	input  logic take_word,
	output qspi_ctrl_pkg::burst_state_t state,
	output logic [qspi_flash_pkg::lane_width-1:0] step_bits,
	output logic [qspi_flash_pkg::count_width-1:0] step_count_load,
	output logic step_shift_fill,
	output logic step_clocked,
	output logic step_ncs,
	output logic burst_restart
);

	qspi_ctrl_pkg::burst_state_t state_next;
	logic [qspi_flash_pkg::step_width-1:0] step_q;
	logic transaction_end;
	logic idle;
	logic abort;

	assign idle = (state == qspi_ctrl_pkg::st_init) || (state == qspi_ctrl_pkg::st_wait);
	assign abort = addr_latched | ~granted; // New start address or lost access
	assign burst_restart = (state == qspi_ctrl_pkg::st_reset);

	// **************************************************
	// State machine
	// **************************************************

	always_comb begin
		state_next = state;
		case (state)
			qspi_ctrl_pkg::st_init: state_next = qspi_ctrl_pkg::st_wait;
			qspi_ctrl_pkg::st_wait: begin
				if (addr_latched && granted && data_request) begin
					state_next = qspi_ctrl_pkg::st_setup;
				end
			end
			qspi_ctrl_pkg::st_setup: state_next = qspi_ctrl_pkg::st_loading;
			qspi_ctrl_pkg::st_loading: state_next = qspi_ctrl_pkg::st_transaction;
			qspi_ctrl_pkg::st_transaction: begin
				if (shift_done) begin
					state_next = qspi_ctrl_pkg::st_check_stop;
				end
			end
			qspi_ctrl_pkg::st_check_stop: begin
				state_next = transaction_end ? qspi_ctrl_pkg::st_reset
					: qspi_ctrl_pkg::st_inc_step;
			end
			qspi_ctrl_pkg::st_inc_step: state_next = qspi_ctrl_pkg::st_setup;
			qspi_ctrl_pkg::st_reset: state_next = qspi_ctrl_pkg::st_dummy;
			qspi_ctrl_pkg::st_dummy: state_next = qspi_ctrl_pkg::st_read;
			qspi_ctrl_pkg::st_read: begin
				// Clock stays low here until the buffer has room
				if (abort) begin
					state_next = qspi_ctrl_pkg::st_wait;
				end else if (take_word) begin
					state_next = qspi_ctrl_pkg::st_read_high;
				end
			end
			qspi_ctrl_pkg::st_read_high: begin
				state_next = abort ? qspi_ctrl_pkg::st_wait : qspi_ctrl_pkg::st_read;
			end
			default: state_next = qspi_ctrl_pkg::st_init;
		endcase
	end

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			state <= qspi_ctrl_pkg::st_init;
		end else if (!data_request) begin
			state <= qspi_ctrl_pkg::st_init;
		end else begin
			state <= state_next;
		end
	end

	// **************************************************
	// Step counter and step selection
	// **************************************************

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			step_q <= '0;
		end else if (idle) begin
			step_q <= '0;
		end else if (state == qspi_ctrl_pkg::st_inc_step) begin
			step_q <= step_q + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			step_ncs <= 1'b1;
			step_clocked <= 1'b0;
			step_shift_fill <= 1'b1;
			transaction_end <= 1'b0;
		end else if (idle) begin
			step_ncs <= 1'b1; // Deselected between bursts
			step_clocked <= 1'b0;
			step_shift_fill <= 1'b1;
			transaction_end <= 1'b0;
		end else if (state == qspi_ctrl_pkg::st_setup) begin
			step_ncs <= qspi_flash_pkg::step_ncs_mask[step_q];
			step_clocked <= qspi_flash_pkg::step_clocked_mask[step_q];
			step_shift_fill <= qspi_flash_pkg::step_fill_mask[step_q];
			transaction_end <= (step_q == qspi_flash_pkg::last_step);
		end else if (state == qspi_ctrl_pkg::st_reset) begin
			transaction_end <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (idle) begin
			step_bits <= qspi_flash_pkg::idle_bits;
			step_count_load <= qspi_flash_pkg::byte_count;
		end else if (state == qspi_ctrl_pkg::st_setup) begin
			step_bits <= qspi_flash_pkg::step_bits_rom[step_q];
			step_count_load <= qspi_flash_pkg::step_count_rom[step_q];
		end
	end

endmodule

/* source/qspi_addr_tracker.sv */
// Addresses must be word aligned; the stop word is inclusive and only words after burst start count
`timescale 1ns/1ps

module qspi_address_tracker (
	input  logic clk,
	input  logic nreset,
	input  logic [qspi_ctrl_pkg::flash_addr_width-1:0] addr_in,
	input  logic [qspi_ctrl_pkg::flash_addr_width-1:0] stop_addr_in,
	input  logic addr_sload,
	input  logic data_request,
	input  logic flash_access_granted,
	input  logic word_taken,
	input  logic burst_restart,
	output logic [qspi_ctrl_pkg::read_addr_width-1:0] read_address,
	output logic addr_latched,
	output logic granted,
	output logic flash_access_request,
	output logic done
);

	logic [qspi_ctrl_pkg::word_addr_width-1:0] word_cnt;
	logic [qspi_ctrl_pkg::word_addr_width-1:0] stop_word;
	logic count_en;

	assign stop_word = stop_addr_in[qspi_ctrl_pkg::flash_addr_width-1:1];
	assign count_en = word_taken & ~addr_latched; // Old burst words are not counted

	// **************************************************
	// Address latch and word counter
	// **************************************************

	always_ff @(posedge clk) begin
		if (addr_sload) begin
			// Each chip holds a quarter of the byte space
			read_address <= {
				{(qspi_ctrl_pkg::read_addr_width - qspi_ctrl_pkg::flash_addr_width + 2){1'b0}},
				addr_in[qspi_ctrl_pkg::flash_addr_width-1:2]
			};
			word_cnt <= addr_in[qspi_ctrl_pkg::flash_addr_width-1:1];
		end else if (count_en) begin
			word_cnt <= word_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			addr_latched <= 1'b0;
		end else if (addr_sload) begin
			addr_latched <= 1'b1;
		end else if (burst_restart) begin
			addr_latched <= 1'b0; // Sequencer has taken the new start
		end
	end

	// Set one cycle after the stop word goes out
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			done <= 1'b0;
		end else if (addr_sload) begin
			done <= 1'b0;
		end else if (count_en && (word_cnt == stop_word)) begin
			done <= 1'b1;
		end
	end

	// **************************************************
	// Flash access request and grant
	// **************************************************

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			flash_access_request <= 1'b0;
			granted <= 1'b0;
		end else begin
			flash_access_request <= data_request;
			if (!data_request) begin
				granted <= 1'b0;
			end else if (!granted) begin
				granted <= flash_access_granted; // Held until request drops
			end
		end
	end

endmodule

/* source/qspi_ctrl_pkg.sv */
// Controller-side widths for a 22-bit byte address; words are two bytes, chip addresses 24 bits
package qspi_ctrl_pkg;

	localparam int flash_addr_width = 22; // Controller byte address
	localparam int word_addr_width = 21; // Byte address without bit 0
	localparam int read_addr_width = 24; // Per-chip address sent on the lanes

	// Burst sequencer states
	typedef enum logic [3:0] {
		st_init,
		st_wait, // Wait for start address, grant and request
		st_setup, // Select the command step
		st_loading, // Load shift registers and bit counter
		st_transaction, // Serial clock running
		st_check_stop,
		st_inc_step,
		st_reset, // Command phase over
		st_dummy,
		st_read, // Clock low, wait for buffer room
		st_read_high // Clock high, lanes sampled
	} burst_state_t;

endpackage

/* source/qspi_flash_pkg.sv */
// Flash-side constants for four chips in parallel; 3-byte addressing and ten dummy clocks only
package qspi_flash_pkg;

	localparam int n_flash = 4; // Chips sharing clock, chip select and lanes
	localparam int data_width = 16; // Four lanes times four chips
	localparam int lane_width = 16; // Length of the io0 shift register
	localparam int addr_cycles = 6; // 24 address bits over four lanes
	localparam int dummy_cycles = 10;
	localparam int count_width = 5;

	localparam int step_count = 6;
	localparam int step_width = 3;
	localparam logic [step_width-1:0] last_step = 3'(step_count - 1);

	typedef enum logic [7:0] {
		op_write_enable = 8'h06,
		op_write_vcr = 8'h81,
		op_quad_read = 8'hEB
	} flash_opcode_t;

	localparam logic [7:0] vcr_value = 8'hFB; // Ten dummy clocks, XIP off

	// **************************************************
	// Command step table, one entry per transaction step
	// **************************************************

	// The bit counter runs two clocks past its load value
	localparam int shift_count_bias = 2;
	localparam logic [count_width-1:0] byte_count = 5'(8 - shift_count_bias);
	localparam logic [count_width-1:0] word_count = 5'(16 - shift_count_bias);
	localparam logic [count_width-1:0] addr_count =
		5'(addr_cycles + dummy_cycles - shift_count_bias);
	localparam logic [count_width-1:0] ncs_gap_count = 5'd31; // Long deselect gap

	localparam logic [lane_width-1:0] idle_bits = 16'hFFFF;

	// Address step is all zero here, the shifter fills in the address
	localparam logic [lane_width-1:0] step_bits_rom [step_count] = '{
		{op_write_enable, 8'hFF},
		idle_bits,
		{op_write_vcr, vcr_value},
		idle_bits,
		{op_quad_read, 8'hFF},
		16'h0000
	};

	localparam logic [count_width-1:0] step_count_rom [step_count] = '{
		byte_count, ncs_gap_count, word_count, ncs_gap_count, byte_count, addr_count
	};

	// Bit i belongs to step i
	localparam logic [step_count-1:0] step_clocked_mask = 6'b110101;
	localparam logic [step_count-1:0] step_ncs_mask = 6'b001010;
	localparam logic [step_count-1:0] step_fill_mask = 6'b011111; // Address step fills zeros

endpackage
